//--- include/dcache_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed geometry: 32-bit address, 64 sets, 16-byte lines
// the address slicing in the RTL assumes these exact values
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

`define DC_ADDR_W    32
`define DC_DATA_W    64
`define DC_STRB_W    8
`define DC_TAG_W     22
`define DC_INDEX_W   6
`define DC_OFFSET_W  4
`define DC_SETS      64
`define DC_WAYS      2
`define DC_LINE_W    128  // two data beats per line

`endif

//--- logic/dcache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// controller states and field types of the data cache
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "dcache_macros.svh"

package dcache_pkg;

  typedef enum logic [2:0] {
    S_IDLE,
    S_HIT,
    S_EVICT_AW,
    S_EVICT_W,
    S_EVICT_B,
    S_FILL_AR,
    S_FILL_R,
    S_REPLAY
  } dc_state_e;

  typedef logic [`DC_TAG_W-1:0]          tag_t;
  typedef logic [`DC_INDEX_W-1:0]        index_t;
  typedef logic [`DC_LINE_W-1:0]         line_t;
  typedef logic [$clog2(`DC_WAYS)-1:0]   way_t;

endpackage

//--- logic/tag_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-way tag, valid and dirty bits with combinational lookup
// victim way comes from a counter that runs every cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "dcache_macros.svh"

module tag_store (
  input  logic               clk,
  input  logic               rst,
  input  dcache_pkg::index_t lookup_index_i,
  input  dcache_pkg::tag_t   lookup_tag_i,
  input  dcache_pkg::way_t   upd_way_i,
  input  dcache_pkg::index_t upd_index_i,
  input  logic               tag_we_i,
  input  dcache_pkg::tag_t   tag_i,
  input  logic               set_valid_i,
  input  logic               clr_valid_i,
  input  logic               set_dirty_i,
  input  logic               clr_dirty_i,
  output logic               hit_o,
  output dcache_pkg::way_t   hit_way_o,
  output dcache_pkg::way_t   victim_way_o,
  output logic               victim_dirty_o,
  output dcache_pkg::tag_t   victim_tag_o
);

  dcache_pkg::tag_t                   tag_q [`DC_WAYS][`DC_SETS];
  logic [`DC_WAYS-1:0][`DC_SETS-1:0]  valid_q;
  logic [`DC_WAYS-1:0][`DC_SETS-1:0]  dirty_q;
  dcache_pkg::way_t                   victim_q;
  logic [`DC_WAYS-1:0]                hit_vec;

  always_ff @(posedge clk) begin
    if (tag_we_i) tag_q[upd_way_i][upd_index_i] <= tag_i;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q  <= '0;
      dirty_q  <= '0;
      victim_q <= '0;
    end else begin
      victim_q <= victim_q + 1'b1;  // free running
      if (set_valid_i) valid_q[upd_way_i][upd_index_i] <= 1'b1;
      else if (clr_valid_i) valid_q[upd_way_i][upd_index_i] <= 1'b0;
      if (set_dirty_i) dirty_q[upd_way_i][upd_index_i] <= 1'b1;
      else if (clr_dirty_i) dirty_q[upd_way_i][upd_index_i] <= 1'b0;
    end
  end

  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      hit_vec[w] = valid_q[w][lookup_index_i] & (tag_q[w][lookup_index_i] == lookup_tag_i);
      if (hit_vec[w]) hit_way_o = dcache_pkg::way_t'(w);
    end
  end

  assign hit_o          = |hit_vec;
  assign victim_way_o   = victim_q;
  assign victim_dirty_o = dirty_q[victim_q][lookup_index_i];
  assign victim_tag_o   = tag_q[victim_q][lookup_index_i];

endmodule

//--- logic/line_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one way of line data, 64 x 128 bits
// read data is registered and holds until the next read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "dcache_macros.svh"

module line_ram (
  input  logic                      clk,
  input  logic                      rd_i,
  input  logic                      wr_i,
  input  dcache_pkg::index_t        index_i,
  input  logic [`DC_LINE_W/8-1:0]   byte_mask_i,
  input  dcache_pkg::line_t         wdata_i,
  output dcache_pkg::line_t         rdata_o
);

  dcache_pkg::line_t mem_q [`DC_SETS];

  always_ff @(posedge clk) begin
    if (wr_i) begin
      for (int b = 0; b < `DC_LINE_W/8; b++) begin
        if (byte_mask_i[b]) mem_q[index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
    if (rd_i) rdata_o <= mem_q[index_i];  // old data on same-cycle write
  end

endmodule

//--- logic/cache_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request FSM: hit, dirty eviction, refill and replay
// a read wins when read and write requests arrive together
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "dcache_macros.svh"

module cache_ctrl (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             ar_valid_i,
  input  logic [`DC_ADDR_W-1:0]            ar_addr_i,
  output logic                             ar_ready_o,
  output logic                             r_data_valid_o,
  output logic [`DC_DATA_W-1:0]            r_data_o,
  input  logic                             r_data_ready_i,
  input  logic                             aw_valid_i,
  input  logic [`DC_ADDR_W-1:0]            aw_addr_i,
  output logic                             aw_ready_o,
  input  logic                             w_data_valid_i,
  input  logic [`DC_STRB_W-1:0]            w_strb_i,
  input  logic [`DC_DATA_W-1:0]            w_data_i,
  output logic                             w_data_ready_o,
  output logic                             b_valid_o,
  input  logic                             b_ready_i,
  output logic                             mem_aw_valid_o,
  output logic [`DC_ADDR_W-1:0]            mem_aw_addr_o,
  input  logic                             mem_aw_ready_i,
  output logic                             mem_w_valid_o,
  output logic [`DC_DATA_W-1:0]            mem_w_data_o,
  input  logic                             mem_w_ready_i,
  input  logic                             mem_b_valid_i,
  output logic                             mem_b_ready_o,
  output logic                             mem_ar_valid_o,
  output logic [`DC_ADDR_W-1:0]            mem_ar_addr_o,
  input  logic                             mem_ar_ready_i,
  input  logic                             mem_r_valid_i,
  input  logic [`DC_DATA_W-1:0]            mem_r_data_i,
  output logic                             mem_r_ready_o,
  output dcache_pkg::index_t               lookup_index_o,
  output dcache_pkg::tag_t                 lookup_tag_o,
  output dcache_pkg::way_t                 upd_way_o,
  output dcache_pkg::index_t               upd_index_o,
  output logic                             tag_we_o,
  output dcache_pkg::tag_t                 tag_o,
  output logic                             set_valid_o,
  output logic                             clr_valid_o,
  output logic                             set_dirty_o,
  output logic                             clr_dirty_o,
  input  logic                             hit_i,
  input  dcache_pkg::way_t                 hit_way_i,
  input  dcache_pkg::way_t                 victim_way_i,
  input  logic                             victim_dirty_i,
  input  dcache_pkg::tag_t                 victim_tag_i,
  output logic [`DC_WAYS-1:0]              ram_rd_o,
  output logic [`DC_WAYS-1:0]              ram_wr_o,
  output dcache_pkg::index_t               ram_index_o,
  output logic [`DC_LINE_W/8-1:0]          ram_mask_o,
  output dcache_pkg::line_t                ram_wdata_o,
  input  dcache_pkg::line_t [`DC_WAYS-1:0] ram_rdata_i
);

  dcache_pkg::dc_state_e state_q, state_d;
  dcache_pkg::tag_t      req_tag_q, evict_tag_q;
  dcache_pkg::index_t    req_index_q;
  dcache_pkg::way_t      way_q;
  logic                  req_half_q;  // high 64-bit half of the line
  logic                  req_wr_q;
  logic                  beat_q;
  logic                  wr_done_q;

  logic [`DC_ADDR_W-1:0] req_addr;
  dcache_pkg::index_t    cur_index;
  dcache_pkg::line_t     sel_line;
  logic                  accept, w_xfer, evict_beat, fill_beat, fill_last, wr_half;
  logic [`DC_STRB_W-1:0] wr_strb;

  assign req_addr   = ar_valid_i ? ar_addr_i : aw_addr_i;
  assign ar_ready_o = (state_q == dcache_pkg::S_IDLE);
  assign aw_ready_o = (state_q == dcache_pkg::S_IDLE) & ~ar_valid_i;
  assign accept     = (ar_valid_i & ar_ready_o) | (aw_valid_i & aw_ready_o);
  assign cur_index  = (state_q == dcache_pkg::S_IDLE) ?
                      req_addr[`DC_OFFSET_W +: `DC_INDEX_W] : req_index_q;
  assign sel_line   = ram_rdata_i[way_q];

  assign r_data_valid_o = (state_q == dcache_pkg::S_HIT) & ~req_wr_q;
  assign r_data_o       = req_half_q ? sel_line[`DC_LINE_W-1 -: `DC_DATA_W]
                                     : sel_line[`DC_DATA_W-1:0];
  assign w_data_ready_o = (state_q == dcache_pkg::S_HIT) & req_wr_q & ~wr_done_q;
  assign b_valid_o      = (state_q == dcache_pkg::S_HIT) & req_wr_q & wr_done_q;

  assign mem_aw_valid_o = (state_q == dcache_pkg::S_EVICT_AW);
  assign mem_aw_addr_o  = {evict_tag_q, req_index_q, {`DC_OFFSET_W{1'b0}}};
  assign mem_w_valid_o  = (state_q == dcache_pkg::S_EVICT_W);
  assign mem_w_data_o   = beat_q ? sel_line[`DC_LINE_W-1 -: `DC_DATA_W]
                                 : sel_line[`DC_DATA_W-1:0];
  assign mem_b_ready_o  = (state_q == dcache_pkg::S_EVICT_B);
  assign mem_ar_valid_o = (state_q == dcache_pkg::S_FILL_AR);
  assign mem_ar_addr_o  = {req_tag_q, req_index_q, {`DC_OFFSET_W{1'b0}}};
  assign mem_r_ready_o  = (state_q == dcache_pkg::S_FILL_R);

  assign w_xfer     = w_data_valid_i & w_data_ready_o;
  assign evict_beat = mem_w_valid_o & mem_w_ready_i;
  assign fill_beat  = mem_r_valid_i & mem_r_ready_o;
  assign fill_last  = fill_beat & beat_q;

  assign lookup_index_o = cur_index;
  assign lookup_tag_o   = (state_q == dcache_pkg::S_IDLE) ?
                          req_addr[`DC_ADDR_W-1 -: `DC_TAG_W] : req_tag_q;
  assign upd_way_o      = way_q;
  assign upd_index_o    = req_index_q;
  assign tag_o          = req_tag_q;
  assign tag_we_o       = fill_last;
  assign set_valid_o    = fill_last;
  assign clr_valid_o    = mem_ar_valid_o & mem_ar_ready_i;  // line is being replaced
  assign set_dirty_o    = w_xfer;
  assign clr_dirty_o    = mem_b_valid_i & mem_b_ready_o;

  // refill beats write a full half, a write hit only its strobed bytes
  assign wr_half     = fill_beat ? beat_q : req_half_q;
  assign wr_strb     = fill_beat ? {`DC_STRB_W{1'b1}} : w_strb_i;
  assign ram_mask_o  = wr_half ? {wr_strb, {`DC_STRB_W{1'b0}}} : {{`DC_STRB_W{1'b0}}, wr_strb};
  assign ram_wdata_o = fill_beat ? {2{mem_r_data_i}} : {2{w_data_i}};
  assign ram_index_o = cur_index;
  assign ram_rd_o    = {`DC_WAYS{accept | (state_q == dcache_pkg::S_REPLAY)}};
  assign ram_wr_o    = (fill_beat | w_xfer) ? (`DC_WAYS'(1) << way_q) : '0;

  always_comb begin
    state_d = state_q;
    case (state_q)
      dcache_pkg::S_IDLE: begin
        if (accept) begin
          if (hit_i) state_d = dcache_pkg::S_HIT;
          else if (victim_dirty_i) state_d = dcache_pkg::S_EVICT_AW;
          else state_d = dcache_pkg::S_FILL_AR;
        end
      end
      dcache_pkg::S_HIT: begin
        if ((r_data_valid_o & r_data_ready_i) | (b_valid_o & b_ready_i)) begin
          state_d = dcache_pkg::S_IDLE;
        end
      end
      dcache_pkg::S_EVICT_AW: if (mem_aw_ready_i) state_d = dcache_pkg::S_EVICT_W;
      dcache_pkg::S_EVICT_W:  if (evict_beat & beat_q) state_d = dcache_pkg::S_EVICT_B;
      dcache_pkg::S_EVICT_B:  if (mem_b_valid_i) state_d = dcache_pkg::S_FILL_AR;
      dcache_pkg::S_FILL_AR:  if (mem_ar_ready_i) state_d = dcache_pkg::S_FILL_R;
      dcache_pkg::S_FILL_R:   if (fill_last) state_d = dcache_pkg::S_REPLAY;
      dcache_pkg::S_REPLAY:   state_d = dcache_pkg::S_HIT;  // both ways reread
      default:                state_d = dcache_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= dcache_pkg::S_IDLE;
      req_wr_q  <= 1'b0;
      beat_q    <= 1'b0;
      wr_done_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) req_wr_q <= ~ar_valid_i;
      beat_q <= beat_q ^ (evict_beat | fill_beat);  // back to 0 after two beats
      if (b_valid_o & b_ready_i) wr_done_q <= 1'b0;
      else if (w_xfer) wr_done_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_tag_q   <= req_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
      req_index_q <= req_addr[`DC_OFFSET_W +: `DC_INDEX_W];
      req_half_q  <= req_addr[`DC_OFFSET_W-1];
      way_q       <= hit_i ? hit_way_i : victim_way_i;
      evict_tag_q <= victim_tag_i;
    end
  end

endmodule

//--- logic/dcache_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-way write-back data cache, one request in flight
// memory bursts are two full-width beats, low half first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ar_valid_i,
  input  logic [`DC_ADDR_W-1:0]  ar_addr_i,
  output logic                   ar_ready_o,
  output logic                   r_data_valid_o,
  output logic [`DC_DATA_W-1:0]  r_data_o,
  input  logic                   r_data_ready_i,
  input  logic                   aw_valid_i,
  input  logic [`DC_ADDR_W-1:0]  aw_addr_i,
  output logic                   aw_ready_o,
  input  logic                   w_data_valid_i,
  input  logic [`DC_STRB_W-1:0]  w_strb_i,
  input  logic [`DC_DATA_W-1:0]  w_data_i,
  output logic                   w_data_ready_o,
  output logic                   b_valid_o,
  input  logic                   b_ready_i,
  output logic                   mem_aw_valid_o,
  output logic [`DC_ADDR_W-1:0]  mem_aw_addr_o,
  input  logic                   mem_aw_ready_i,
  output logic                   mem_w_valid_o,
  output logic [`DC_DATA_W-1:0]  mem_w_data_o,
  input  logic                   mem_w_ready_i,
  input  logic                   mem_b_valid_i,
  output logic                   mem_b_ready_o,
  output logic                   mem_ar_valid_o,
  output logic [`DC_ADDR_W-1:0]  mem_ar_addr_o,
  input  logic                   mem_ar_ready_i,
  input  logic                   mem_r_valid_i,
  input  logic [`DC_DATA_W-1:0]  mem_r_data_i,
  output logic                   mem_r_ready_o
);

  dcache_pkg::index_t               lookup_index, upd_index, ram_index;
  dcache_pkg::tag_t                 lookup_tag, upd_tag, victim_tag;
  dcache_pkg::way_t                 upd_way, hit_way, victim_way;
  logic                             tag_we, set_valid, clr_valid, set_dirty, clr_dirty;
  logic                             hit, victim_dirty;
  logic [`DC_WAYS-1:0]              ram_rd, ram_wr;
  logic [`DC_LINE_W/8-1:0]          ram_mask;
  dcache_pkg::line_t                ram_wdata;
  dcache_pkg::line_t [`DC_WAYS-1:0] way_rdata;

  // processor and memory pins share names with the controller ports
  cache_ctrl u_ctrl (
    .*,
    .lookup_index_o (lookup_index),
    .lookup_tag_o   (lookup_tag),
    .upd_way_o      (upd_way),
    .upd_index_o    (upd_index),
    .tag_we_o       (tag_we),
    .tag_o          (upd_tag),
    .set_valid_o    (set_valid),
    .clr_valid_o    (clr_valid),
    .set_dirty_o    (set_dirty),
    .clr_dirty_o    (clr_dirty),
    .hit_i          (hit),
    .hit_way_i      (hit_way),
    .victim_way_i   (victim_way),
    .victim_dirty_i (victim_dirty),
    .victim_tag_i   (victim_tag),
    .ram_rd_o       (ram_rd),
    .ram_wr_o       (ram_wr),
    .ram_index_o    (ram_index),
    .ram_mask_o     (ram_mask),
    .ram_wdata_o    (ram_wdata),
    .ram_rdata_i    (way_rdata)
  );

  tag_store u_tags (
    .clk            (clk),
    .rst            (rst),
    .lookup_index_i (lookup_index),
    .lookup_tag_i   (lookup_tag),
    .upd_way_i      (upd_way),
    .upd_index_i    (upd_index),
    .tag_we_i       (tag_we),
    .tag_i          (upd_tag),
    .set_valid_i    (set_valid),
    .clr_valid_i    (clr_valid),
    .set_dirty_i    (set_dirty),
    .clr_dirty_i    (clr_dirty),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .victim_way_o   (victim_way),
    .victim_dirty_o (victim_dirty),
    .victim_tag_o   (victim_tag)
  );

  line_ram u_way0 (
    .clk         (clk),
    .rd_i        (ram_rd[0]),
    .wr_i        (ram_wr[0]),
    .index_i     (ram_index),
    .byte_mask_i (ram_mask),
    .wdata_i     (ram_wdata),
    .rdata_o     (way_rdata[0])
  );

  line_ram u_way1 (
    .clk         (clk),
    .rd_i        (ram_rd[1]),
    .wr_i        (ram_wr[1]),
    .index_i     (ram_index),
    .byte_mask_i (ram_mask),
    .wdata_i     (ram_wdata),
    .rdata_o     (way_rdata[1])
  );

endmodule

//--- verification/tb_clock.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 10 ns clock, reset high for the first 4 rising edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;  // released at the drive point
  end

endmodule

//--- verification/dcache_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshake rules of cache_ctrl, bound in by the testbench
// fail_count is read back by the testbench at the end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_properties (
  input logic                  clk,
  input logic                  rst,
  input logic                  ar_ready_i,
  input logic                  r_data_valid_i,
  input logic                  r_data_ready_i,
  input logic [`DC_DATA_W-1:0] r_data_i,
  input logic                  b_valid_i,
  input logic                  b_ready_i,
  input logic                  mem_aw_valid_i,
  input logic                  mem_aw_ready_i,
  input logic [`DC_ADDR_W-1:0] mem_aw_addr_i,
  input logic                  mem_w_valid_i,
  input logic                  mem_w_ready_i,
  input logic [`DC_DATA_W-1:0] mem_w_data_i,
  input logic                  mem_ar_valid_i,
  input logic                  mem_ar_ready_i,
  input logic [`DC_ADDR_W-1:0] mem_ar_addr_i
);

  int unsigned fail_count = 0;

  aw_hold: assert property (@(posedge clk) disable iff (rst)
      mem_aw_valid_i && !mem_aw_ready_i |=> mem_aw_valid_i && $stable(mem_aw_addr_i))
    else begin
      $error("mem_aw_valid dropped or its address moved before the handshake");
      fail_count++;
    end

  w_hold: assert property (@(posedge clk) disable iff (rst)
      mem_w_valid_i && !mem_w_ready_i |=> mem_w_valid_i && $stable(mem_w_data_i))
    else begin
      $error("mem_w_valid dropped or its data moved before the handshake");
      fail_count++;
    end

  ar_hold: assert property (@(posedge clk) disable iff (rst)
      mem_ar_valid_i && !mem_ar_ready_i |=> mem_ar_valid_i && $stable(mem_ar_addr_i))
    else begin
      $error("mem_ar_valid dropped or its address moved before the handshake");
      fail_count++;
    end

  r_hold: assert property (@(posedge clk) disable iff (rst)
      r_data_valid_i && !r_data_ready_i |=> r_data_valid_i && $stable(r_data_i))
    else begin
      $error("r_data_valid dropped or read data moved before the handshake");
      fail_count++;
    end

  b_hold: assert property (@(posedge clk) disable iff (rst)
      b_valid_i && !b_ready_i |=> b_valid_i)
    else begin
      $error("b_valid dropped before the handshake");
      fail_count++;
    end

  // no new request while memory traffic is open
  busy_not_ready: assert property (@(posedge clk) disable iff (rst)
      (mem_aw_valid_i || mem_w_valid_i || mem_ar_valid_i) |-> !ar_ready_i)
    else begin
      $error("ar_ready high during memory traffic");
      fail_count++;
    end

  one_response: assert property (@(posedge clk) disable iff (rst)
      !(b_valid_i && r_data_valid_i))
    else begin
      $error("b_valid and r_data_valid high together");
      fail_count++;
    end

endmodule

//--- verification/dcache_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random reads and writes over 3 sets, checked against a reference memory
// the testbench is also the memory slave, with random ready and valid delays
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_tb;

  localparam int unsigned TIMEOUT = 300;
  localparam int NUM_REQ = 2000;
  localparam int WAIT_AR = 0;
  localparam int WAIT_R  = 1;
  localparam int WAIT_AW = 2;
  localparam int WAIT_WD = 3;
  localparam int WAIT_B  = 4;

  logic                  clk, rst;
  logic                  ar_valid_i, r_data_ready_i, aw_valid_i, w_data_valid_i, b_ready_i;
  logic                  ar_ready_o, r_data_valid_o, aw_ready_o, w_data_ready_o, b_valid_o;
  logic [`DC_ADDR_W-1:0] ar_addr_i, aw_addr_i, mem_aw_addr_o, mem_ar_addr_o;
  logic [`DC_STRB_W-1:0] w_strb_i;
  logic [`DC_DATA_W-1:0] w_data_i, r_data_o, mem_w_data_o, mem_r_data_i;
  logic                  mem_aw_valid_o, mem_w_valid_o, mem_b_ready_o, mem_ar_valid_o;
  logic                  mem_r_ready_o, mem_aw_ready_i, mem_w_ready_i, mem_b_valid_i;
  logic                  mem_ar_ready_i, mem_r_valid_i;

  logic [63:0] ref_mem [logic [31:0]];      // expected contents, by word address
  logic [63:0] mem_store [logic [31:0]];    // memory slave backing store
  bit          dirty_lines [logic [27:0]];  // written, not yet written back
  logic [21:0] tag_pool [4] = '{22'h00011, 22'h0a5c3, 22'h3ff00, 22'h12345};
  logic [5:0]  set_pool [3] = '{6'd5, 6'd6, 6'd40};
  logic [27:0] prev_line;
  logic [31:0] wr_line, rd_line;
  logic        fill_seen, rd_active, b_owed;
  int          wr_beats, rd_beats;

  tb_clock u_clock (.clk(clk), .rst(rst));

  dcache_top i_dut (.*);

  bind cache_ctrl dcache_properties u_props (
    .clk(clk), .rst(rst), .ar_ready_i(ar_ready_o),
    .r_data_valid_i(r_data_valid_o), .r_data_ready_i(r_data_ready_i), .r_data_i(r_data_o),
    .b_valid_i(b_valid_o), .b_ready_i(b_ready_i),
    .mem_aw_valid_i(mem_aw_valid_o), .mem_aw_ready_i(mem_aw_ready_i),
    .mem_aw_addr_i(mem_aw_addr_o), .mem_w_valid_i(mem_w_valid_o),
    .mem_w_ready_i(mem_w_ready_i), .mem_w_data_i(mem_w_data_o),
    .mem_ar_valid_i(mem_ar_valid_o), .mem_ar_ready_i(mem_ar_ready_i),
    .mem_ar_addr_i(mem_ar_addr_o)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                          input string what);
    if (actual !== expected) begin
      abort_run($sformatf("error %0t: %s, got %h, expected %h", $time, what, actual, expected));
    end
  endtask

  task automatic step_to_drive();
    @(posedge clk);
    #1;
  endtask

  function automatic logic coin();
    return ($urandom % 2) == 0;
  endfunction

  function automatic logic [63:0] fill_word(input logic [31:0] a);
    return {a ^ 32'hc3a5_0f1e, ~a};  // untouched memory
  endfunction

  function automatic logic [63:0] ref_read(input logic [31:0] a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
  endfunction

  function automatic logic [63:0] mem_read(input logic [31:0] a);
    return mem_store.exists(a) ? mem_store[a] : fill_word(a);
  endfunction

  function automatic int pending_in_set(input logic [5:0] set);
    int n;
    n = 0;
    foreach (dirty_lines[l]) if (l[5:0] == set) n++;
    return n;
  endfunction

  function automatic logic handshake_ready(input int sel);
    case (sel)
      WAIT_AR: return ar_ready_o;
      WAIT_R:  return r_data_valid_o;
      WAIT_AW: return aw_ready_o;
      WAIT_WD: return w_data_ready_o;
      default: return b_valid_o;
    endcase
  endfunction

  // returns at the falling edge before the transfer edge
  task automatic wait_for(input int sel, input string what, output int unsigned cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) abort_run($sformatf("timeout at %0t: %s never came", $time, what));
    end while (!handshake_ready(sel));
  endtask

  task automatic do_read(input logic [31:0] addr);
    int unsigned lat;
    logic        same_line;
    same_line = (addr[31:4] == prev_line);
    fill_seen = 1'b0;
    ar_valid_i = 1'b1;
    ar_addr_i = addr;
    wait_for(WAIT_AR, "ar_ready_o", lat);
    step_to_drive();
    ar_valid_i = 1'b0;
    wait_for(WAIT_R, "r_data_valid_o", lat);
    check_eq(r_data_o, ref_read(addr), $sformatf("read data at %h", addr));
    check_eq(rd_active, 0, "refill burst still open at read response");
    if (same_line) check_eq(fill_seen, 0, "refill of a resident line");
    if (!fill_seen) check_eq(lat, 1, "read hit latency");
    repeat ($urandom % 3) step_to_drive();  // back-pressure
    step_to_drive();
    r_data_ready_i = 1'b1;
    step_to_drive();
    r_data_ready_i = 1'b0;
    prev_line = addr[31:4];
  endtask

  task automatic do_write(input logic [31:0] addr, input logic [7:0] strb,
                          input logic [63:0] data);
    int unsigned cycles;
    logic [63:0] word;
    aw_valid_i = 1'b1;
    aw_addr_i = addr;
    wait_for(WAIT_AW, "aw_ready_o", cycles);
    step_to_drive();
    aw_valid_i = 1'b0;
    repeat ($urandom % 3) step_to_drive();
    w_data_valid_i = 1'b1;
    w_strb_i = strb;
    w_data_i = data;
    wait_for(WAIT_WD, "w_data_ready_o", cycles);
    check_eq(rd_active, 0, "refill burst still open at write data");
    word = ref_read(addr);
    for (int b = 0; b < 8; b++) if (strb[b]) word[b*8 +: 8] = data[b*8 +: 8];
    ref_mem[addr] = word;
    dirty_lines[addr[31:4]] = 1'b1;
    step_to_drive();
    w_data_valid_i = 1'b0;
    wait_for(WAIT_B, "b_valid_o", cycles);
    repeat ($urandom % 3) step_to_drive();
    step_to_drive();
    b_ready_i = 1'b1;
    step_to_drive();
    b_ready_i = 1'b0;
    prev_line = addr[31:4];
  endtask

  // memory slave, samples at the falling edge and drives after the rising edge
  initial begin
    logic aw_fire, w_fire, b_fire, ar_fire, r_fire, b_rdy;
    rd_active = 1'b0;
    b_owed = 1'b0;
    wr_beats = 0;
    rd_beats = 0;
    forever begin
      @(negedge clk);
      aw_fire = mem_aw_valid_o & mem_aw_ready_i;
      w_fire = mem_w_valid_o & mem_w_ready_i;
      b_fire = mem_b_valid_i & mem_b_ready_o;
      ar_fire = mem_ar_valid_o & mem_ar_ready_i;
      r_fire = mem_r_valid_i & mem_r_ready_o;
      b_rdy = mem_b_ready_o;
      if (mem_aw_valid_o || mem_ar_valid_o) fill_seen = 1'b1;
      if (aw_fire) begin
        check_eq(mem_aw_addr_o[3:0], 0, "eviction address alignment");
        wr_line = mem_aw_addr_o;
        wr_beats = 0;
        b_owed = 1'b1;  // answered once the controller waits for it
        if (dirty_lines.exists(mem_aw_addr_o[31:4])) dirty_lines.delete(mem_aw_addr_o[31:4]);
      end
      if (w_fire) begin
        check_eq(wr_beats < 2, 1, "eviction beat past the end of the burst");
        mem_store[wr_line + 8 * wr_beats] = mem_w_data_o;  // low half first
        wr_beats++;
      end
      if (b_fire) begin
        check_eq(wr_beats, 2, "eviction beats per burst");
        b_owed = 1'b0;
        wr_beats = 0;
      end
      if (ar_fire) begin
        check_eq(mem_ar_addr_o[3:0], 0, "refill address alignment");
        rd_line = mem_ar_addr_o;
        rd_beats = 0;
        rd_active = 1'b1;
      end
      if (r_fire) begin
        rd_beats++;
        if (rd_beats == 2) rd_active = 1'b0;
      end
      step_to_drive();
      mem_aw_ready_i = coin();
      mem_w_ready_i = coin();
      mem_ar_ready_i = coin();
      if (b_fire) mem_b_valid_i = 1'b0;
      if (b_owed && b_rdy && !mem_b_valid_i && coin()) mem_b_valid_i = 1'b1;
      if (r_fire) mem_r_valid_i = 1'b0;
      if (rd_active && !mem_r_valid_i && coin()) begin
        mem_r_valid_i = 1'b1;
        mem_r_data_i = mem_read(rd_line + 8 * rd_beats);
      end
    end
  end

  initial begin
    int unsigned cycles;
    int          flush_tag;
    logic [31:0] addr;
    void'($urandom(32'hae59_76ce));
    {ar_valid_i, r_data_ready_i, aw_valid_i, w_data_valid_i, b_ready_i} = '0;
    {mem_aw_ready_i, mem_w_ready_i, mem_b_valid_i, mem_ar_ready_i, mem_r_valid_i} = '0;
    ar_addr_i = '0;
    aw_addr_i = '0;
    w_strb_i = '0;
    w_data_i = '0;
    mem_r_data_i = '0;
    prev_line = '1;
    #1;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) abort_run("reset was never released");
    end while (rst);
    check_eq(ar_ready_o, 1, "ar_ready_o after reset");
    check_eq(aw_ready_o, 1, "aw_ready_o after reset");
    check_eq({r_data_valid_o, w_data_ready_o, b_valid_o, mem_aw_valid_o, mem_w_valid_o,
              mem_ar_valid_o}, 0, "valid outputs after reset");
    step_to_drive();

    for (int n = 0; n < NUM_REQ; n++) begin
      addr = {tag_pool[$urandom % 4], set_pool[$urandom % 3], 1'($urandom % 2), 3'b000};
      if (coin()) do_read(addr);
      else do_write(addr, 8'($urandom), {$urandom, $urandom});
    end

    // conflicting reads push every written line out to memory
    flush_tag = 0;
    foreach (set_pool[s]) begin
      while (pending_in_set(set_pool[s]) != 0 && flush_tag < 256) begin
        do_read({22'h200000 + 22'(flush_tag), set_pool[s], 4'h0});
        flush_tag++;
      end
      check_eq(pending_in_set(set_pool[s]), 0, "dirty lines left after flush");
    end
    foreach (ref_mem[a]) check_eq(mem_read(a), ref_mem[a], $sformatf("memory word %h", a));

    if (i_dut.u_ctrl.u_props.fail_count == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      abort_run("handshake assertions failed during the run");
    end
  end

endmodule

//--- compile.f
+incdir+include
logic/dcache_pkg.sv
logic/tag_store.sv
logic/line_ram.sv
logic/cache_ctrl.sv
logic/dcache_top.sv
verification/tb_clock.sv
verification/dcache_properties.sv
verification/dcache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the data cache testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module dcache_tb \
  --Mdir obj_dir -o dcache_sim || { echo "build failed"; exit 1; }
out="$(./obj_dir/dcache_sim)"
echo "$out"
grep -qx "Test passed" <<< "$out" && exit 0 || exit 1
